// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	// Each frame is a start bit, the data MSB first, one even parity bit and the stop bits
	localparam int DATA_BITS = 8;
	localparam int STOP_BITS = 2;
	localparam int FRAME_BITS = 1 + DATA_BITS + 1 + STOP_BITS;

	// One bit lasts OVERSAMPLE ticks and one tick lasts CLKS_PER_TICK clocks
	localparam int OVERSAMPLE = 16;
	localparam int CLKS_PER_TICK = 2;

	localparam int FIFO_DEPTH = 4;

	// Counter and pointer widths that follow from the numbers above
	localparam int DIV_CNT_W = $clog2(CLKS_PER_TICK);
	localparam int TICK_CNT_W = $clog2(OVERSAMPLE);
	localparam int FRAME_CNT_W = $clog2(FRAME_BITS);
	localparam int DATA_CNT_W = $clog2(DATA_BITS);
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	// Outcome of one received frame
	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic parity_error;
		logic framing_error;
	} rx_record_t;

endpackage

`default_nettype wire

// ==== uart_rx_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface uart_rx_if;
	import uart_pkg::*;

	logic valid;
	logic [DATA_BITS-1:0] data;
	logic parity_error;
	logic framing_error;

	// Packed view of the payload in the layout the receive FIFO stores
	rx_record_t record;

	assign record = {data, parity_error, framing_error};

	// The receiver drives the fields, the FIFO side takes valid and the packed record
	modport source (output valid, output data, output parity_error, output framing_error);
	modport sink (input valid, input record);

endinterface

`default_nettype wire

// ==== uart_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tick_gen (
	input logic Clk,
	input logic Rst,
	output logic tick
);
	import uart_pkg::*;

	logic [DIV_CNT_W-1:0] div_cnt;

	// Tick is registered so both state machines see a clean single-clock strobe
	always_ff @(posedge Clk or posedge Rst) begin
		if (Rst) begin
			div_cnt <= '0;
			tick <= 1'b0;
		end else if (div_cnt == DIV_CNT_W'(CLKS_PER_TICK - 1)) begin
			div_cnt <= '0;
			tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick <= 1'b0;
		end
	end

	// Bit timing in both state machines counts ticks, so a stretched tick would count twice
	tick_single_clock: assert property (@(posedge Clk) disable iff (Rst) tick |=> !tick)
		else $error("uart_tick_gen: tick high for two clocks");

endmodule

`default_nettype wire

// ==== uart_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
	parameter type T = logic [uart_pkg::DATA_BITS-1:0]
) (
	input logic Clk,
	input logic Rst,
	input logic write,
	input T write_data,
	input logic read,
	output T read_data,
	output logic full,
	output logic empty
);
	import uart_pkg::*;

	T mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_write;
	logic do_read;

	// Strobes against a full or empty FIFO are dropped here
	assign do_write = write && !full;
	assign do_read = read && !empty;

	assign full = (count == (PTR_W + 1)'(FIFO_DEPTH));
	assign empty = (count == '0);

	// Show-ahead head
	assign read_data = mem[rd_ptr];

	always_ff @(posedge Clk) begin
		if (do_write) begin
			mem[wr_ptr] <= write_data;
		end
	end

	always_ff @(posedge Clk or posedge Rst) begin
		if (Rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	count_in_range: assert property (@(posedge Clk) disable iff (Rst) count <= FIFO_DEPTH)
		else $error("uart_fifo: occupancy %0d above depth", count);

	full_empty_exclusive: assert property (@(posedge Clk) disable iff (Rst) !(full && empty))
		else $error("uart_fifo: full and empty both high");

endmodule

`default_nettype wire

// ==== uart_tx_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fsm (
	input logic Clk,
	input logic Rst,
	input logic tick,
	input logic [uart_pkg::DATA_BITS-1:0] data,
	input logic empty,
	output logic read,
	input logic cts,
	output logic tx
);
	import uart_pkg::*;

	typedef enum logic [1:0] {IDLE = 2'b00, START = 2'b01, LOOP = 2'b10} tx_state_t;

	tx_state_t state_q, state_d;

	logic [DATA_BITS-1:0] data_q;
	logic parity_q;
	logic [FRAME_BITS-1:0] frame;
	logic [TICK_CNT_W-1:0] tick_cnt;
	logic [FRAME_CNT_W-1:0] bit_cnt;
	logic bit_end;
	logic last_bit;

	// Start bit sits at the top so the frame goes out from the MSB down
	assign frame = {1'b0, data_q, parity_q, {STOP_BITS{1'b1}}};

	assign bit_end = tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1));
	assign last_bit = (bit_cnt == '0);

	// Pop the FIFO head as the frame is latched
	assign read = (state_q == IDLE) && !empty;

	always_ff @(posedge Clk or posedge Rst) begin
		if (Rst) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: begin
				if (!empty) begin
					state_d = START;
				end
			end
			START: begin
				// CTS only gates the start; a started frame always runs to the end
				if (tick && cts) begin
					state_d = LOOP;
				end
			end
			LOOP: begin
				if (bit_end && last_bit) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	// Even parity, so the parity bit is the XOR of the data bits
	always_ff @(posedge Clk) begin
		if (read) begin
			data_q <= data;
			parity_q <= ^data;
		end
	end

	// bit_cnt indexes the frame and counts down to the last stop bit
	always_ff @(posedge Clk or posedge Rst) begin
		if (Rst) begin
			tx <= 1'b1;
			tick_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			unique case (state_q)
				START: begin
					if (tick && cts) begin
						tx <= frame[FRAME_BITS-1];
						tick_cnt <= '0;
						bit_cnt <= FRAME_CNT_W'(FRAME_BITS - 1);
					end
				end
				LOOP: begin
					if (bit_end) begin
						tick_cnt <= '0;
						if (last_bit) begin
							tx <= 1'b1;
						end else begin
							tx <= frame[bit_cnt - 1'b1];
							bit_cnt <= bit_cnt - 1'b1;
						end
					end else if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default: tx <= 1'b1;
			endcase
		end
	end

	// The FIFO would drop this pop and the frame would carry a stale head
	no_pop_when_empty: assert property (@(posedge Clk) disable iff (Rst) read |-> !empty)
		else $error("uart_tx_fsm: read strobe while transmit FIFO empty");

endmodule

`default_nettype wire

// ==== uart_rx_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fsm (
	input logic Clk,
	input logic Rst,
	input logic tick,
	input logic rx,
	uart_rx_if.source rec
);
	import uart_pkg::*;

	typedef enum logic [2:0] {
		IDLE = 3'd0,
		START = 3'd1,
		DATA = 3'd2,
		PARITY = 3'd3,
		STOP = 3'd4
	} rx_state_t;

	rx_state_t state;

	logic rx_meta;
	logic rx_sync;
	logic [TICK_CNT_W-1:0] tick_cnt;
	logic [DATA_CNT_W-1:0] bit_cnt;
	logic [DATA_BITS-1:0] data_q;
	logic parity_q;
	logic framing_q;
	logic valid_q;
	logic start_sample;
	logic bit_sample;

	// The line is asynchronous to Clk
	always_ff @(posedge Clk or posedge Rst) begin
		if (Rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// Half a bit after the falling edge, then a full bit between later samples
	assign start_sample = tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE / 2 - 1));
	assign bit_sample = tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1));

	always_ff @(posedge Clk or posedge Rst) begin
		if (Rst) begin
			state <= IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (tick) begin
				tick_cnt <= tick_cnt + 1'b1;
			end
			unique case (state)
				IDLE: begin
					tick_cnt <= '0;
					if (!rx_sync) begin
						state <= START;
					end
				end
				START: begin
					// A high line at mid-bit was a glitch, not a start bit
					if (start_sample) begin
						tick_cnt <= '0;
						bit_cnt <= '0;
						state <= rx_sync ? IDLE : DATA;
					end
				end
				DATA: begin
					if (bit_sample) begin
						tick_cnt <= '0;
						if (bit_cnt == DATA_CNT_W'(DATA_BITS - 1)) begin
							bit_cnt <= '0;
							state <= PARITY;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				PARITY: begin
					if (bit_sample) begin
						tick_cnt <= '0;
						state <= STOP;
					end
				end
				STOP: begin
					if (bit_sample) begin
						tick_cnt <= '0;
						if (bit_cnt == DATA_CNT_W'(STOP_BITS - 1)) begin
							valid_q <= 1'b1;
							state <= IDLE;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Data arrives MSB first, so shift in from the bottom
	always_ff @(posedge Clk) begin
		if (state == START && start_sample) begin
			framing_q <= 1'b0;
		end
		if (state == DATA && bit_sample) begin
			data_q <= {data_q[DATA_BITS-2:0], rx_sync};
		end
		if (state == PARITY && bit_sample) begin
			parity_q <= rx_sync;
		end
		// Any low stop sample marks the frame
		if (state == STOP && bit_sample && !rx_sync) begin
			framing_q <= 1'b1;
		end
	end

	assign rec.valid = valid_q;
	assign rec.data = data_q;
	assign rec.parity_error = parity_q ^ (^data_q);
	assign rec.framing_error = framing_q;

	// The receive FIFO writes on every valid clock, so a long strobe would duplicate a record
	valid_single_clock: assert property (@(posedge Clk) disable iff (Rst) rec.valid |=> !rec.valid)
		else $error("uart_rx_fsm: valid held for more than one clock");

endmodule

`default_nettype wire

// ==== uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_top (
	input logic Clk,
	input logic Rst,
	input logic [uart_pkg::DATA_BITS-1:0] tx_data,
	input logic tx_write,
	output logic tx_full,
	output logic [uart_pkg::DATA_BITS-1:0] rx_data,
	output logic rx_parity_error,
	output logic rx_framing_error,
	input logic rx_read,
	output logic rx_empty,
	output logic tx,
	input logic rx,
	input logic cts,
	output logic rts
);
	import uart_pkg::*;

	logic tick;
	logic [DATA_BITS-1:0] tx_head;
	logic tx_empty;
	logic tx_pop;
	rx_record_t rx_head;
	logic rx_full;

	uart_rx_if rx_bus ();

	// One tick source so both directions share the same bit timing
	uart_tick_gen u_tick_gen (
		.Clk(Clk),
		.Rst(Rst),
		.tick(tick)
	);

	uart_fifo #(.T(logic [DATA_BITS-1:0])) u_tx_fifo (
		.Clk(Clk),
		.Rst(Rst),
		.write(tx_write),
		.write_data(tx_data),
		.read(tx_pop),
		.read_data(tx_head),
		.full(tx_full),
		.empty(tx_empty)
	);

	uart_tx_fsm u_tx_fsm (
		.Clk(Clk),
		.Rst(Rst),
		.tick(tick),
		.data(tx_head),
		.empty(tx_empty),
		.read(tx_pop),
		.cts(cts),
		.tx(tx)
	);

	uart_rx_fsm u_rx_fsm (
		.Clk(Clk),
		.Rst(Rst),
		.tick(tick),
		.rx(rx),
		.rec(rx_bus.source)
	);

	// Records that arrive while full are dropped by the FIFO itself
	uart_fifo #(.T(rx_record_t)) u_rx_fifo (
		.Clk(Clk),
		.Rst(Rst),
		.write(rx_bus.valid),
		.write_data(rx_bus.record),
		.read(rx_read),
		.read_data(rx_head),
		.full(rx_full),
		.empty(rx_empty)
	);

	assign rx_data = rx_head.data;
	assign rx_parity_error = rx_head.parity_error;
	assign rx_framing_error = rx_head.framing_error;

	// The far end may send while there is room for another record
	assign rts = !rx_full;

endmodule

`default_nettype wire

// ==== uart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tb;
	import uart_pkg::*;

	localparam int BIT_CLKS = OVERSAMPLE * CLKS_PER_TICK;
	localparam int RX_TIMEOUT = 4 * FRAME_BITS * BIT_CLKS;

	logic Clk;
	logic Rst;
	logic [DATA_BITS-1:0] tx_data;
	logic tx_write;
	logic tx_full;
	logic [DATA_BITS-1:0] rx_data;
	logic rx_parity_error;
	logic rx_framing_error;
	logic rx_read;
	logic rx_empty;
	logic tx_line;
	logic rx_line;
	logic cts;
	logic rts;

	logic loopback;
	logic line_bit;
	logic hold_check;
	logic [31:0] lfsr_state;
	logic [DATA_BITS-1:0] expected [$];

	// The serial input is either the DUT's own tx or the frame driver below
	assign rx_line = loopback ? tx_line : line_bit;

	uart_top DUT (
		.Clk(Clk),
		.Rst(Rst),
		.tx_data(tx_data),
		.tx_write(tx_write),
		.tx_full(tx_full),
		.rx_data(rx_data),
		.rx_parity_error(rx_parity_error),
		.rx_framing_error(rx_framing_error),
		.rx_read(rx_read),
		.rx_empty(rx_empty),
		.tx(tx_line),
		.rx(rx_line),
		.cts(cts),
		.rts(rts)
	);

	always #2 Clk = ~Clk;

	task automatic stop_with_failure();
		$display("*** FAILED ***");
		$fatal(1, "uart_tb stopped at the first error");
	endtask

	task automatic report_mismatch(input string test, input logic [31:0] exp_value,
		input logic [31:0] act_value);
		$display("FAIL %s: expected 0x%0h actual 0x%0h", test, exp_value, act_value);
		stop_with_failure();
	endtask

	task automatic report_error(input string what);
		$display("ERROR: %s", what);
		stop_with_failure();
	endtask

	// Taps 32, 22, 2 and 1 give a maximal-length sequence
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic random_byte(output logic [DATA_BITS-1:0] value);
		int i;
		value = '0;
		for (i = 0; i < DATA_BITS; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[DATA_BITS-2:0], lfsr_state[0]};
		end
	endtask

	// A byte written while the FIFO is full is not expected back
	task automatic write_byte(input logic [DATA_BITS-1:0] value, input logic kept);
		@(negedge Clk);
		tx_data = value;
		tx_write = 1'b1;
		if (kept) begin
			expected.push_back(value);
		end
		@(negedge Clk);
		tx_write = 1'b0;
	endtask

	task automatic wait_rx_ready(input string test);
		int cycles;
		cycles = 0;
		while (rx_empty) begin
			@(negedge Clk);
			cycles++;
			if (cycles > RX_TIMEOUT) begin
				report_error({"timeout waiting for a received record in ", test});
			end
		end
	endtask

	task automatic check_record(input string test, input logic [DATA_BITS-1:0] exp_data,
		input logic exp_parity, input logic exp_framing);
		wait_rx_ready(test);
		assert (rx_data == exp_data)
			else report_mismatch({test, " data"}, 32'(exp_data), 32'(rx_data));
		assert (rx_parity_error == exp_parity)
			else report_mismatch({test, " parity"}, 32'(exp_parity), 32'(rx_parity_error));
		assert (rx_framing_error == exp_framing)
			else report_mismatch({test, " framing"}, 32'(exp_framing), 32'(rx_framing_error));
		rx_read = 1'b1;
		@(negedge Clk);
		rx_read = 1'b0;
	endtask

	task automatic check_next(input string test);
		logic [DATA_BITS-1:0] value;
		if (expected.size() == 0) begin
			report_error({"no byte left to compare against in ", test});
		end
		value = expected.pop_front();
		check_record(test, value, 1'b0, 1'b0);
	endtask

	// Start bit, data MSB first, even parity, then the stop bits
	task automatic drive_frame(input logic [DATA_BITS-1:0] value, input logic flip_parity,
		input logic low_stop);
		logic [FRAME_BITS-1:0] bits;
		int i;
		bits = {1'b0, value, (^value) ^ flip_parity, {STOP_BITS{1'b1}}};
		if (low_stop) begin
			bits[STOP_BITS-1] = 1'b0;
		end
		for (i = FRAME_BITS - 1; i >= 0; i--) begin
			@(negedge Clk);
			line_bit = bits[i];
			repeat (BIT_CLKS - 1) @(negedge Clk);
		end
	endtask

	tx_held_by_cts: assert property (@(posedge Clk) disable iff (Rst) hold_check |-> tx_line)
		else report_error("tx left the idle level while cts was low");

	// Frames that the DUT builds itself never carry an error
	loopback_clean: assert property (@(posedge Clk) disable iff (Rst)
		(loopback && !rx_empty) |-> !(rx_parity_error || rx_framing_error))
		else report_error("a looped-back record carries an error flag");

	initial begin
		logic [DATA_BITS-1:0] value;
		int i;
		Clk = 1'b0;
		Rst = 1'b1;
		tx_data = '0;
		tx_write = 1'b0;
		rx_read = 1'b0;
		cts = 1'b1;
		loopback = 1'b1;
		line_bit = 1'b1;
		hold_check = 1'b0;
		lfsr_state = 32'h6b89_5387;
		repeat (5) @(posedge Clk);
		@(negedge Clk);
		Rst = 1'b0;
		@(negedge Clk);

		assert (tx_line == 1'b1) else report_mismatch("reset tx", 32'd1, 32'(tx_line));
		assert (rts == 1'b1) else report_mismatch("reset rts", 32'd1, 32'(rts));
		assert (rx_empty == 1'b1) else report_mismatch("reset rx_empty", 32'd1, 32'(rx_empty));
		assert (tx_full == 1'b0) else report_mismatch("reset tx_full", 32'd0, 32'(tx_full));

		for (i = 0; i < 4; i++) begin
			random_byte(value);
			write_byte(value, 1'b1);
		end
		for (i = 0; i < 4; i++) begin
			check_next("loopback order");
		end

		cts = 1'b0;
		hold_check = 1'b1;
		for (i = 0; i < 2; i++) begin
			random_byte(value);
			write_byte(value, 1'b1);
		end
		repeat (3 * BIT_CLKS) @(negedge Clk);
		hold_check = 1'b0;
		cts = 1'b1;
		for (i = 0; i < 2; i++) begin
			check_next("cts hold");
		end

		// The transmitter holds one popped byte, so one write beyond the depth fills the FIFO
		cts = 1'b0;
		hold_check = 1'b1;
		// The record arrives at mid stop bit, so the transmitter needs up to half a bit more
		repeat (BIT_CLKS) @(negedge Clk);
		for (i = 0; i <= FIFO_DEPTH; i++) begin
			random_byte(value);
			write_byte(value, 1'b1);
		end
		assert (tx_full == 1'b1) else report_mismatch("tx back-pressure full", 32'd1, 32'(tx_full));
		random_byte(value);
		write_byte(value, 1'b0);
		hold_check = 1'b0;
		cts = 1'b1;
		for (i = 0; i <= FIFO_DEPTH; i++) begin
			check_next("tx back-pressure");
		end
		repeat (2 * FRAME_BITS * BIT_CLKS) @(negedge Clk);
		assert (rx_empty == 1'b1)
			else report_mismatch("tx back-pressure extra frame", 32'd1, 32'(rx_empty));

		loopback = 1'b0;
		random_byte(value);
		drive_frame(value, 1'b1, 1'b0);
		check_record("parity error", value, 1'b1, 1'b0);

		random_byte(value);
		drive_frame(value, 1'b0, 1'b1);
		check_record("framing error", value, 1'b0, 1'b1);

		for (i = 0; i < FIFO_DEPTH; i++) begin
			assert (rts == 1'b1) else report_mismatch("rts before full", 32'd1, 32'(rts));
			random_byte(value);
			expected.push_back(value);
			drive_frame(value, 1'b0, 1'b0);
		end
		assert (rts == 1'b0) else report_mismatch("rts when full", 32'd0, 32'(rts));
		// This frame finds the receive FIFO full and is lost
		random_byte(value);
		drive_frame(value, 1'b0, 1'b0);
		check_next("receive fill");
		assert (rts == 1'b1) else report_mismatch("rts after one read", 32'd1, 32'(rts));
		for (i = 1; i < FIFO_DEPTH; i++) begin
			check_next("receive fill");
		end
		assert (rx_empty == 1'b1)
			else report_mismatch("receive overflow dropped", 32'd1, 32'(rx_empty));

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
uart_pkg.sv
uart_rx_if.sv
uart_tick_gen.sv
uart_fifo.sv
uart_tx_fsm.sv
uart_rx_fsm.sv
uart_top.sv
uart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= uart_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
